// File: run_sim.sh
#!/usr/bin/env bash
# Build the board-control testbench with Verilator, run it and check the log
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
   -f sources.f \
   --top-module bus_int_tb \
   -Mdir obj_dir

./obj_dir/Vbus_int_tb | tee "$LOG"

if grep -q ">>> FAIL" "$LOG"; then
   echo "simulation reported failure, see $LOG"
   exit 1
fi

echo "simulation finished without failure"

// File: sources.f
+incdir+src
src/sfpp_pkg.sv
src/ctrl_bus_pkg.sv
src/setting_reg.sv
src/sfpp_port.sv
src/readback_mux.sv
src/bus_int.sv
testbench/bus_int_tb.sv

// File: src/bus_int.sv
/* Board-control register block: LED, soft-reset and clock-control registers,
   two SFP+ cages and the readback mux */

`timescale 1ns/1ns
`include "bus_int_consts.svh"

module bus_int (
   input  logic                   clk,
   input  logic                   i_rst_n,
   input  ctrl_bus_pkg::set_bus_t i_set,
   input  ctrl_bus_pkg::rb_req_t  i_rb,
   input  logic [7:0]             i_clock_status,
   input  sfpp_pkg::sfpp_pins_t   i_sfpp0_pins,
   input  sfpp_pkg::sfpp_pins_t   i_sfpp1_pins,
   input  logic [15:0]            i_eth0_phy_status,
   input  logic [15:0]            i_eth1_phy_status,
   output logic [31:0]            o_rb_data,
   output logic [7:0]             o_leds,
   output logic [3:0]             o_sw_rst,
   output logic [7:0]             o_clock_ctrl,
   output logic [1:0]             o_sfpp0_rs_drive,
   output logic [1:0]             o_sfpp1_rs_drive
);

   sfpp_pkg::sfpp_status_t sfpp0_status;
   sfpp_pkg::sfpp_status_t sfpp1_status;
   logic [1:0]             sfpp_clr;

   // ----------------------------------------------------------------------
   // Control registers
   // ----------------------------------------------------------------------
   setting_reg #(.my_addr(`BI_SR_LEDS), .width(8)) leds_reg_inst (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .i_set   (i_set),
      .o_q     (o_leds)
   );

   // Soft reset bits
   //   0 PHY, 1 radio clock domain, 2 radio clock PLL, 3 ADC delay control
   setting_reg #(.my_addr(`BI_SR_SW_RST), .width(4)) sw_rst_reg_inst (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .i_set   (i_set),
      .o_q     (o_sw_rst)
   );

   setting_reg #(
      .my_addr  (`BI_SR_CLOCK_CTRL),
      .width    (8),
      .at_reset (`BI_CLOCK_CTRL_RESET)
   ) clock_ctrl_reg_inst (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .i_set   (i_set),
      .o_q     (o_clock_ctrl)
   );

   // ----------------------------------------------------------------------
   // SFP+ cages
   // ----------------------------------------------------------------------
   sfpp_port #(.ctrl_addr(`BI_SR_SFPP_CTRL0)) sfpp0_inst (
      .clk          (clk),
      .i_rst_n      (i_rst_n),
      .i_set        (i_set),
      .i_pins       (i_sfpp0_pins),
      .i_phy_status (i_eth0_phy_status),
      .i_clr        (sfpp_clr[0]),
      .o_status     (sfpp0_status),
      .o_rs_drive   (o_sfpp0_rs_drive)
   );

   sfpp_port #(.ctrl_addr(`BI_SR_SFPP_CTRL1)) sfpp1_inst (
      .clk          (clk),
      .i_rst_n      (i_rst_n),
      .i_set        (i_set),
      .i_pins       (i_sfpp1_pins),
      .i_phy_status (i_eth1_phy_status),
      .i_clr        (sfpp_clr[1]),
      .o_status     (sfpp1_status),
      .o_rs_drive   (o_sfpp1_rs_drive)
   );

   // ----------------------------------------------------------------------
   // Readback
   // ----------------------------------------------------------------------
   readback_mux readback_mux_inst (
      .clk            (clk),
      .i_rst_n        (i_rst_n),
      .i_rb           (i_rb),
      .i_clock_status (i_clock_status),
      .i_sfpp0_status (sfpp0_status),
      .i_sfpp1_status (sfpp1_status),
      .o_rb_data      (o_rb_data),
      .o_sfpp_clr     (sfpp_clr)
   );

endmodule

// File: src/bus_int_consts.svh
/* Bus widths, settings and readback addresses
   Reset values and fixed readback constants for the board-control block */

`ifndef BUS_INT_CONSTS_SVH
`define BUS_INT_CONSTS_SVH

// ----------------------------------------------------------------------
// Bus widths
// ----------------------------------------------------------------------
`define BI_SET_AW 8
`define BI_SET_DW 32
`define BI_RB_AW  8

// ----------------------------------------------------------------------
// Settings register addresses
// ----------------------------------------------------------------------
`define BI_SR_LEDS       8'd0
`define BI_SR_SW_RST     8'd1
`define BI_SR_CLOCK_CTRL 8'd2
`define BI_SR_SFPP_CTRL0 8'd8
`define BI_SR_SFPP_CTRL1 8'd9

// ----------------------------------------------------------------------
// Readback addresses
// ----------------------------------------------------------------------
`define BI_RB_COUNTER      8'd0
`define BI_RB_CLK_STATUS   8'd3
`define BI_RB_ETH_TYPE0    8'd4
`define BI_RB_ETH_TYPE1    8'd5
`define BI_RB_COMPAT_NUM   8'd6
`define BI_RB_NUM_CE       8'd7
`define BI_RB_SFPP_STATUS0 8'd8
`define BI_RB_SFPP_STATUS1 8'd9

// Bit 6 turns the GPS-disciplined oscillator on
`define BI_CLOCK_CTRL_RESET 8'h40

`define BI_COMPAT_MAJOR 16'd1000
`define BI_COMPAT_MINOR 16'd0
`define BI_NUM_CE       3

// Ethernet port type, 0 for 1G and 1 for 10G
`define BI_ETH_TYPE0 1'b0
`define BI_ETH_TYPE1 1'b0

`endif

// File: src/ctrl_bus_pkg.sv
/* Settings-write and readback-request bus structs
   Readback word union with raw and SFP+ status views */

`include "bus_int_consts.svh"

package ctrl_bus_pkg;

   // ----------------------------------------------------------------------
   // Settings bus
   // ----------------------------------------------------------------------

   // One write, stb is a single-cycle pulse
   typedef struct packed {
      logic                  stb;
      logic [`BI_SET_AW-1:0] addr;
      logic [`BI_SET_DW-1:0] data;
   } set_bus_t;

   // ----------------------------------------------------------------------
   // Readback bus
   // ----------------------------------------------------------------------

   // Addr is a level, rd_stb marks a consumed read
   typedef struct packed {
      logic                 rd_stb;
      logic [`BI_RB_AW-1:0] addr;
   } rb_req_t;

   // Same readback word seen two ways
   typedef union packed {
      logic [31:0]            raw;
      sfpp_pkg::sfpp_status_t sfpp;
   } rb_word_u;

endpackage

// File: src/readback_mux.sv
/* Free-running cycle counter, readback word select
   and clear-on-read pulses for the SFP+ change flags */

`timescale 1ns/1ns
`include "bus_int_consts.svh"

module readback_mux (
   input  logic                   clk,
   input  logic                   i_rst_n,
   input  ctrl_bus_pkg::rb_req_t  i_rb,
   input  logic [7:0]             i_clock_status,
   input  sfpp_pkg::sfpp_status_t i_sfpp0_status,
   input  sfpp_pkg::sfpp_status_t i_sfpp1_status,
   output logic [31:0]            o_rb_data,
   output logic [1:0]             o_sfpp_clr
);

   logic [31:0]            counter;
   ctrl_bus_pkg::rb_word_u word;

   // Cycle counter
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         counter <= '0;
      end else begin
         counter <= counter + 32'd1;
      end
   end

   // ----------------------------------------------------------------------
   // Readback select, zero latency from the address
   // ----------------------------------------------------------------------
   always_comb begin
      word.raw = '0;
      case (i_rb.addr)
         `BI_RB_COUNTER:      word.raw = counter;
         `BI_RB_CLK_STATUS:   word.raw = {24'd0, i_clock_status};
         `BI_RB_ETH_TYPE0:    word.raw = {31'd0, `BI_ETH_TYPE0};
         `BI_RB_ETH_TYPE1:    word.raw = {31'd0, `BI_ETH_TYPE1};
         `BI_RB_COMPAT_NUM:   word.raw = {`BI_COMPAT_MAJOR, `BI_COMPAT_MINOR};
         `BI_RB_NUM_CE:       word.raw = 32'(`BI_NUM_CE);
         // SFP+ words go through the status view
         `BI_RB_SFPP_STATUS0: word.sfpp = i_sfpp0_status;
         `BI_RB_SFPP_STATUS1: word.sfpp = i_sfpp1_status;
         default:             word.raw = '0;
      endcase
   end

   assign o_rb_data = word.raw;

   // Clear pulses, only on a consumed read of the matching word
   assign o_sfpp_clr[0] = i_rb.rd_stb && (i_rb.addr == `BI_RB_SFPP_STATUS0);
   assign o_sfpp_clr[1] = i_rb.rd_stb && (i_rb.addr == `BI_RB_SFPP_STATUS1);

   // One read clears at most one cage
   a_one_clr : assert property (@(posedge clk) disable iff (!i_rst_n)
      o_sfpp_clr != 2'b11)
      else $error("readback_mux cleared both SFP+ ports at once");

endmodule

// File: src/setting_reg.sv
/* Single settings-bus register with its own address */

`timescale 1ns/1ns
`include "bus_int_consts.svh"

module setting_reg #(
   parameter logic [`BI_SET_AW-1:0] my_addr  = '0,
   parameter int                    width    = 8,
   parameter logic [width-1:0]      at_reset = '0
) (
   input  logic                   clk,
   input  logic                   i_rst_n,
   input  ctrl_bus_pkg::set_bus_t i_set,
   output logic [width-1:0]       o_q
);

   logic hit;

   // Address decode for this register
   assign hit = i_set.stb && (i_set.addr == my_addr);

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_q <= at_reset;
      end else if (hit) begin
         // Low bits of the data word only
         o_q <= i_set.data[width-1:0];
      end
   end

   // Register must fit in one settings data word
   a_width_fits : assert property (@(posedge clk) width <= `BI_SET_DW)
      else $error("setting_reg width %0d exceeds data width", width);

endmodule

// File: src/sfpp_pkg.sv
/* SFP+ cage pin struct and SFP+ status word layout */

package sfpp_pkg;

   // Module presence, transmit fault, receive loss of signal
   typedef struct packed {
      logic mod_abs;
      logic tx_fault;
      logic rx_los;
   } sfpp_pins_t;

   // Status word as seen on the readback bus
   typedef struct packed {
      logic [15:0] phy_status;
      logic [9:0]  reserved;
      sfpp_pins_t  chgd;
      sfpp_pins_t  level;
   } sfpp_status_t;

endpackage

// File: src/sfpp_port.sv
/* One SFP+ cage: pin and PHY status synchronizers, sticky change flags
   and the rate-select drive register */

`timescale 1ns/1ns
`include "bus_int_consts.svh"

module sfpp_port #(
   parameter logic [`BI_SET_AW-1:0] ctrl_addr = '0
) (
   input  logic                   clk,
   input  logic                   i_rst_n,
   input  ctrl_bus_pkg::set_bus_t i_set,
   input  sfpp_pkg::sfpp_pins_t   i_pins,
   input  logic [15:0]            i_phy_status,
   input  logic                   i_clr,
   output sfpp_pkg::sfpp_status_t o_status,
   output logic [1:0]             o_rs_drive
);

   sfpp_pkg::sfpp_pins_t pin_meta;
   sfpp_pkg::sfpp_pins_t pin_sync;
   sfpp_pkg::sfpp_pins_t pin_prev;
   sfpp_pkg::sfpp_pins_t chgd;
   logic [15:0]          phy_meta;
   logic [15:0]          phy_sync;

   // ----------------------------------------------------------------------
   // Rate select, one drive enable per RS pin
   // ----------------------------------------------------------------------
   setting_reg #(
      .my_addr  (ctrl_addr),
      .width    (2),
      .at_reset (2'b00)
   ) rs_reg_inst (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .i_set   (i_set),
      .o_q     (o_rs_drive)
   );

   // ----------------------------------------------------------------------
   // Two-flop synchronizers
   // ----------------------------------------------------------------------

   // Cage pins are asynchronous to clk
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         pin_meta <= '0;
         pin_sync <= '0;
      end else begin
         pin_meta <= i_pins;
         pin_sync <= pin_meta;
      end
   end

   // Every PHY status bit treated as independent
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         phy_meta <= '0;
         phy_sync <= '0;
      end else begin
         phy_meta <= i_phy_status;
         phy_sync <= phy_meta;
      end
   end

   // ----------------------------------------------------------------------
   // Change detection
   // ----------------------------------------------------------------------
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         pin_prev <= '0;
      end else begin
         pin_prev <= pin_sync;
      end
   end

   // Sticky until read; an edge in the clearing cycle is dropped
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         chgd <= '0;
      end else if (i_clr) begin
         chgd <= '0;
      end else begin
         chgd <= sfpp_pkg::sfpp_pins_t'(chgd | (pin_sync ^ pin_prev));
      end
   end

   always_comb begin
      o_status.phy_status = phy_sync;
      o_status.reserved   = '0;
      o_status.chgd       = chgd;
      o_status.level      = pin_sync;
   end

   // A set change flag only drops through a read from the readback mux
   a_chgd_sticky : assert property (@(posedge clk) disable iff (!i_rst_n)
      !i_clr |=> ((chgd & $past(chgd)) == $past(chgd)))
      else $error("sfpp_port change flag cleared without a read");

endmodule

// File: testbench/bus_int_tb.sv
/* Testbench for the board-control block: clock, reset, step table,
   step loop with checks, timeout and summary */

`timescale 1ns/1ns
`include "bus_int_consts.svh"

module bus_int_tb;

   typedef enum int {K_WRITE, K_READ, K_READ_STB, K_PINS, K_IDLE, K_CHECK} kind_t;

   logic                   clk = 1'b0;
   logic                   rst_n;
   ctrl_bus_pkg::set_bus_t set_bus;
   ctrl_bus_pkg::rb_req_t  rb_req;
   logic [7:0]             clock_status;
   sfpp_pkg::sfpp_pins_t   sfpp0_pins;
   sfpp_pkg::sfpp_pins_t   sfpp1_pins;
   logic [15:0]            eth0_phy;
   logic [15:0]            eth1_phy;
   logic [31:0]            rb_data;
   logic [7:0]             leds;
   logic [3:0]             sw_rst;
   logic [7:0]             clock_ctrl;
   logic [1:0]             rs0_drive;
   logic [1:0]             rs1_drive;

   // Step table with one entry per index
   string       names[$];
   kind_t       kinds[$];
   logic [7:0]  addrs[$];
   logic [31:0] datas[$];
   logic [2:0]  pinss[$];
   logic [31:0] exps[$];

   int          seed = 74;
   int          passed = 0;
   int          failed = 0;
   int          cycle_count = 0;
   int          cycle_limit = 100000;
   logic [31:0] last_count = '0;
   logic        have_count = 1'b0;

   bus_int bus_int_inst (
      .clk               (clk),
      .i_rst_n           (rst_n),
      .i_set             (set_bus),
      .i_rb              (rb_req),
      .i_clock_status    (clock_status),
      .i_sfpp0_pins      (sfpp0_pins),
      .i_sfpp1_pins      (sfpp1_pins),
      .i_eth0_phy_status (eth0_phy),
      .i_eth1_phy_status (eth1_phy),
      .o_rb_data         (rb_data),
      .o_leds            (leds),
      .o_sw_rst          (sw_rst),
      .o_clock_ctrl      (clock_ctrl),
      .o_sfpp0_rs_drive  (rs0_drive),
      .o_sfpp1_rs_drive  (rs1_drive)
   );

   always #2 clk = ~clk;

   // Run limit from the table length
   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count > cycle_limit) begin
         $display("timeout after %0d cycles, the step loop did not finish", cycle_count);
         $display(">>> FAIL");
         $finish;
      end
   end

   // ----------------------------------------------------------------------
   // Table helpers
   // ----------------------------------------------------------------------
   task automatic add_step(input string n, input kind_t k, input logic [7:0] a,
                           input logic [31:0] d, input logic [2:0] p,
                           input logic [31:0] e);
      names.push_back(n);
      kinds.push_back(k);
      addrs.push_back(a);
      datas.push_back(d);
      pinss.push_back(p);
      exps.push_back(e);
   endtask

   // SFP+ word from phy status, 10 zero bits, change flags and levels
   function automatic logic [31:0] status_word(input logic [15:0] phy,
                                               input logic [2:0] chg,
                                               input logic [2:0] lvl);
      return {phy, 10'd0, chg, lvl};
   endfunction

   // Register output picked by its settings address
   function automatic logic [31:0] output_value(input logic [7:0] sel);
      case (sel)
         `BI_SR_LEDS:       return {24'd0, leds};
         `BI_SR_SW_RST:     return {28'd0, sw_rst};
         `BI_SR_CLOCK_CTRL: return {24'd0, clock_ctrl};
         `BI_SR_SFPP_CTRL0: return {30'd0, rs0_drive};
         `BI_SR_SFPP_CTRL1: return {30'd0, rs1_drive};
         default:           return '1;
      endcase
   endfunction

   task automatic check_value(input int i, input logic [31:0] actual);
      logic ok;
      ok = (actual === exps[i]);
      assert (ok) else begin
         failed++;
         $display("mismatch %s expected %h actual %h", names[i], exps[i], actual);
      end
      if (ok) begin
         passed++;
         $display("ok       %s", names[i]);
      end
   endtask

   task automatic note_done(input int i, input string what);
      passed++;
      $display("ok       %s (%s)", names[i], what);
   endtask

   // ----------------------------------------------------------------------
   // One step entered and left 1 ns after a rising edge
   // ----------------------------------------------------------------------
   task automatic run_step(input int i);
      logic [31:0] actual;
      actual = '0;
      case (kinds[i])
         K_WRITE: begin
            set_bus.stb  = 1'b1;
            set_bus.addr = addrs[i];
            set_bus.data = datas[i];
            @(posedge clk);
            #1;
            set_bus.stb = 1'b0;
            note_done(i, "write");
         end
         K_READ, K_READ_STB: begin
            rb_req.addr   = addrs[i];
            rb_req.rd_stb = (kinds[i] == K_READ_STB);
            #1;
            actual = rb_data;
            @(posedge clk);
            #1;
            rb_req.rd_stb = 1'b0;
            // Counter reads compare the step against the previous sample
            if (addrs[i] == `BI_RB_COUNTER) begin
               if (have_count) begin
                  check_value(i, actual - last_count);
               end else begin
                  note_done(i, "reference sample");
               end
               last_count = actual;
               have_count = 1'b1;
            end else begin
               check_value(i, actual);
            end
         end
         K_PINS: begin
            if (addrs[i] == 8'd0) begin
               sfpp0_pins = sfpp_pkg::sfpp_pins_t'(pinss[i]);
               eth0_phy   = datas[i][15:0];
            end else begin
               sfpp1_pins = sfpp_pkg::sfpp_pins_t'(pinss[i]);
               eth1_phy   = datas[i][15:0];
            end
            @(posedge clk);
            #1;
            note_done(i, "pins set");
         end
         K_IDLE: begin
            repeat (int'(datas[i])) @(posedge clk);
            #1;
            note_done(i, "idle");
         end
         default: begin
            check_value(i, output_value(addrs[i]));
            @(posedge clk);
            #1;
         end
      endcase
   endtask

   // ----------------------------------------------------------------------
   // Table, reset, loop and summary
   // ----------------------------------------------------------------------
   initial begin
      logic [31:0] led_pat;
      logic [31:0] rst_pat;
      logic [31:0] clk_pat;
      logic [31:0] rs_pat;
      logic [31:0] stat_pat;
      logic [31:0] phy0_pat;
      logic [31:0] phy1_pat;
      int          total;
      led_pat  = $random(seed);
      rst_pat  = $random(seed);
      clk_pat  = $random(seed);
      rs_pat   = $random(seed);
      stat_pat = $random(seed);
      phy0_pat = $random(seed);
      phy1_pat = $random(seed);

      rst_n        = 1'b0;
      set_bus      = '0;
      rb_req       = '0;
      clock_status = stat_pat[7:0];
      sfpp0_pins   = '0;
      sfpp1_pins   = '0;
      eth0_phy     = '0;
      eth1_phy     = '0;

      add_step("reset_leds", K_CHECK, `BI_SR_LEDS, 32'd0, 3'd0, 32'd0);
      add_step("reset_sw_rst", K_CHECK, `BI_SR_SW_RST, 32'd0, 3'd0, 32'd0);
      add_step("reset_clock_ctrl", K_CHECK, `BI_SR_CLOCK_CTRL, 32'd0, 3'd0, 32'h40);
      add_step("reset_rs0", K_CHECK, `BI_SR_SFPP_CTRL0, 32'd0, 3'd0, 32'd0);
      add_step("reset_rs1", K_CHECK, `BI_SR_SFPP_CTRL1, 32'd0, 3'd0, 32'd0);

      // Writes land truncated to the register width
      add_step("wr_leds", K_WRITE, `BI_SR_LEDS, led_pat, 3'd0, 32'd0);
      add_step("leds", K_CHECK, `BI_SR_LEDS, 32'd0, 3'd0, {24'd0, led_pat[7:0]});
      add_step("wr_sw_rst", K_WRITE, `BI_SR_SW_RST, rst_pat, 3'd0, 32'd0);
      add_step("sw_rst", K_CHECK, `BI_SR_SW_RST, 32'd0, 3'd0, {28'd0, rst_pat[3:0]});
      add_step("wr_clock_ctrl", K_WRITE, `BI_SR_CLOCK_CTRL, clk_pat, 3'd0, 32'd0);
      add_step("clock_ctrl", K_CHECK, `BI_SR_CLOCK_CTRL, 32'd0, 3'd0, {24'd0, clk_pat[7:0]});
      add_step("wr_rs0", K_WRITE, `BI_SR_SFPP_CTRL0, rs_pat, 3'd0, 32'd0);
      add_step("rs0", K_CHECK, `BI_SR_SFPP_CTRL0, 32'd0, 3'd0, {30'd0, rs_pat[1:0]});
      add_step("wr_rs1", K_WRITE, `BI_SR_SFPP_CTRL1, ~rs_pat, 3'd0, 32'd0);
      add_step("rs1", K_CHECK, `BI_SR_SFPP_CTRL1, 32'd0, 3'd0, {30'd0, ~rs_pat[1:0]});
      add_step("wr_unmapped", K_WRITE, 8'h20, 32'hffff_ffff, 3'd0, 32'd0);
      add_step("leds_kept", K_CHECK, `BI_SR_LEDS, 32'd0, 3'd0, {24'd0, led_pat[7:0]});
      add_step("sw_rst_kept", K_CHECK, `BI_SR_SW_RST, 32'd0, 3'd0, {28'd0, rst_pat[3:0]});
      add_step("clock_ctrl_kept", K_CHECK, `BI_SR_CLOCK_CTRL, 32'd0, 3'd0,
               {24'd0, clk_pat[7:0]});
      add_step("rs0_kept", K_CHECK, `BI_SR_SFPP_CTRL0, 32'd0, 3'd0, {30'd0, rs_pat[1:0]});
      add_step("rs1_kept", K_CHECK, `BI_SR_SFPP_CTRL1, 32'd0, 3'd0, {30'd0, ~rs_pat[1:0]});

      add_step("rd_compat", K_READ, `BI_RB_COMPAT_NUM, 32'd0, 3'd0, 32'h03e8_0000);
      add_step("rd_num_ce", K_READ, `BI_RB_NUM_CE, 32'd0, 3'd0, 32'd3);
      add_step("rd_eth_type0", K_READ, `BI_RB_ETH_TYPE0, 32'd0, 3'd0, 32'd0);
      add_step("rd_eth_type1", K_READ, `BI_RB_ETH_TYPE1, 32'd0, 3'd0, 32'd0);
      add_step("rd_clk_status", K_READ, `BI_RB_CLK_STATUS, 32'd0, 3'd0, {24'd0, stat_pat[7:0]});
      add_step("rd_unmapped_2", K_READ, 8'h02, 32'd0, 3'd0, 32'd0);
      add_step("rd_unmapped_42", K_READ, 8'h42, 32'd0, 3'd0, 32'd0);

      // Port 0 loses its module and port 1 sees fault and loss of signal
      add_step("pins0_mod_abs", K_PINS, 8'd0, phy0_pat, 3'b100, 32'd0);
      add_step("settle0", K_IDLE, 8'd0, 32'd4, 3'd0, 32'd0);
      add_step("sfpp0_changed", K_READ, `BI_RB_SFPP_STATUS0, 32'd0, 3'd0,
               status_word(phy0_pat[15:0], 3'b100, 3'b100));
      add_step("sfpp1_quiet", K_READ, `BI_RB_SFPP_STATUS1, 32'd0, 3'd0, 32'd0);
      add_step("pins1_los_fault", K_PINS, 8'd1, phy1_pat, 3'b011, 32'd0);
      add_step("settle1", K_IDLE, 8'd0, 32'd4, 3'd0, 32'd0);

      // Clearing port 0 leaves the port 1 flags set
      add_step("sfpp0_strobed", K_READ_STB, `BI_RB_SFPP_STATUS0, 32'd0, 3'd0,
               status_word(phy0_pat[15:0], 3'b100, 3'b100));
      add_step("sfpp0_cleared", K_READ, `BI_RB_SFPP_STATUS0, 32'd0, 3'd0,
               status_word(phy0_pat[15:0], 3'b000, 3'b100));
      add_step("sfpp1_strobed", K_READ_STB, `BI_RB_SFPP_STATUS1, 32'd0, 3'd0,
               status_word(phy1_pat[15:0], 3'b011, 3'b011));
      add_step("sfpp1_cleared", K_READ, `BI_RB_SFPP_STATUS1, 32'd0, 3'd0,
               status_word(phy1_pat[15:0], 3'b000, 3'b011));
      add_step("sfpp0_unchanged", K_READ, `BI_RB_SFPP_STATUS0, 32'd0, 3'd0,
               status_word(phy0_pat[15:0], 3'b000, 3'b100));

      // Expected delta is the read cycle plus the idle cycles before the next read
      add_step("count_ref", K_READ, `BI_RB_COUNTER, 32'd0, 3'd0, 32'd0);
      add_step("count_gap5", K_IDLE, 8'd0, 32'd5, 3'd0, 32'd0);
      add_step("count_delta6", K_READ, `BI_RB_COUNTER, 32'd0, 3'd0, 32'd6);
      add_step("count_delta1", K_READ, `BI_RB_COUNTER, 32'd0, 3'd0, 32'd1);
      add_step("count_gap10", K_IDLE, 8'd0, 32'd10, 3'd0, 32'd0);
      add_step("count_delta11", K_READ, `BI_RB_COUNTER, 32'd0, 3'd0, 32'd11);

      total = 0;
      for (int i = 0; i < names.size(); i++) begin
         total += (kinds[i] == K_IDLE) ? int'(datas[i]) : 1;
      end
      cycle_limit = 4 + total + 20;

      repeat (4) @(posedge clk);
      #1;
      rst_n = 1'b1;

      for (int i = 0; i < names.size(); i++) begin
         run_step(i);
      end

      $display("tests %0d, passed %0d, failed %0d", passed + failed, passed, failed);
      if (failed == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule
